/* Makefile */
SRCS = rtl/decodePkg.sv rtl/instrFetch.sv rtl/pipeReg.sv rtl/controlUnit.sv \
       rtl/decodeStage.sv rtl/decodeTop.sv test/decodeTb.sv

obj_dir/VdecodeTb: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module decodeTb -f sources.f -o VdecodeTb

run: obj_dir/VdecodeTb
	@out="$$(./obj_dir/VdecodeTb)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

.PHONY: run clean

/* rtl/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit (
  input  logic [5:0]      opcode,
  output decodePkg::ctrlT ctrl
);

  import decodePkg::*;

  always_comb
  begin
    // Most common values first
    ctrl          = '0;
    ctrl.regWrite = 1'b1;
    ctrl.memToReg = 1'b1;
    ctrl.aluOp    = aluAdd;
    ctrl.loadMode = loadWord;

    case (opcode)
      opR:
      begin
        ctrl.regDst = 1'b1;
        ctrl.aluOp  = aluFunct;
      end
      opAddi:
      begin
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = aluAdd;
      end
      opLw:
      begin
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b0;
        ctrl.loadMode = loadWord;
      end
      opLh:
      begin
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b0;
        ctrl.loadMode = loadHalf;
      end
      opLhu:
      begin
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b0;
        ctrl.loadMode = loadHalfU;
      end
      opSw:
      begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
        ctrl.memWrite = 1'b1;
      end
      opBeq:
      begin
        ctrl.regWrite = 1'b0;
        ctrl.aluOp    = aluSub;
        ctrl.branch   = 1'b1;
      end
      opAndi:
      begin
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = aluAnd;
      end
      opOri:
      begin
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = aluOr;
      end
      default:
      begin
        // Unknown opcode acts as a no-op
        ctrl.regWrite = 1'b0;
        ctrl.aluOp    = aluAdd;
      end
    endcase
  end

  always_comb
  begin
    memExclusive: assert (!(ctrl.memRead && ctrl.memWrite))
      else $error("memRead and memWrite both set for opcode %h", opcode);
  end

endmodule

/* rtl/decodePkg.sv */
package decodePkg;

  // Opcodes
  localparam logic [5:0] opR    = 6'b000_000;
  localparam logic [5:0] opAddi = 6'b001_000;
  localparam logic [5:0] opLw   = 6'b100_011;
  localparam logic [5:0] opLh   = 6'b100_001;
  localparam logic [5:0] opLhu  = 6'b100_101;
  localparam logic [5:0] opSw   = 6'b101_011;
  localparam logic [5:0] opBeq  = 6'b000_100;
  localparam logic [5:0] opAndi = 6'b001_100;
  localparam logic [5:0] opOri  = 6'b001_101;

  // ALU operations with aluSub doubling as the branch compare
  localparam logic [2:0] aluAdd   = 3'b000;
  localparam logic [2:0] aluSub   = 3'b001;
  localparam logic [2:0] aluOr    = 3'b010;
  localparam logic [2:0] aluAnd   = 3'b011;
  localparam logic [2:0] aluFunct = 3'b100;

  // Load widths
  localparam logic [1:0] loadWord  = 2'b00;
  localparam logic [1:0] loadHalf  = 2'b01;
  localparam logic [1:0] loadHalfU = 2'b10;

  localparam logic [31:0] pcStep = 32'd4;

  typedef struct packed {
    logic       regDst;
    logic       regWrite;
    logic       aluSrc;
    logic [2:0] aluOp;
    logic       memWrite;
    logic       memRead;
    logic       memToReg;
    logic       branch;
    logic [1:0] loadMode;
  } ctrlT;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetchT;

  typedef struct packed {
    logic [31:0] pc;
    ctrlT        ctrl;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] immExt;
    logic [4:0]  destReg;
    logic [5:0]  funct;
  } idExT;

  // Write-back port into the register file
  typedef struct packed {
    logic        en;
    logic [4:0]  addr;
    logic [31:0] data;
  } wbT;

endpackage

/* rtl/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage (
  input  logic             clk,
  input  logic             arstN,
  input  decodePkg::fetchT fetchIn,
  input  decodePkg::wbT    wb,
  output decodePkg::idExT  idOut
);

  import decodePkg::*;

  logic [31:0] regs [32];
  logic [5:0]  opcode;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [15:0] imm;
  logic [31:0] rsData;
  logic [31:0] rtData;
  ctrlT        ctrl;

  // Read port with write-back bypass and r0 hardwired to zero
  function automatic logic [31:0] readReg(input logic [4:0] addr);
    logic [31:0] value;
    if (addr == 5'd0)
      value = '0;
    else if (wb.en && wb.addr == addr)
      value = wb.data;
    else
      value = regs[addr];
    return value;
  endfunction

  assign opcode = fetchIn.instr[31:26];
  assign rs     = fetchIn.instr[25:21];
  assign rt     = fetchIn.instr[20:16];
  assign rd     = fetchIn.instr[15:11];
  assign imm    = fetchIn.instr[15:0];

  controlUnit u_ctrl (
    .opcode(opcode),
    .ctrl  (ctrl)
  );

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wb.en && wb.addr != 5'd0)
    begin
      regs[wb.addr] <= wb.data;
    end
  end

  // Operands follow both the register file and the write-back port
  always_comb
  begin
    rsData = readReg(rs);
    rtData = readReg(rt);
  end

  assign idOut.pc      = fetchIn.pc;
  assign idOut.ctrl    = ctrl;
  assign idOut.rsData  = rsData;
  assign idOut.rtData  = rtData;
  assign idOut.immExt  = {{16{imm[15]}}, imm};
  assign idOut.destReg = ctrl.regDst ? rd : rt;
  assign idOut.funct   = fetchIn.instr[5:0];

  regZero: assert property (
    @(posedge clk) disable iff (!arstN) regs[0] == '0
  ) else $error("register 0 changed to %h", regs[0]);

endmodule

/* rtl/decodeTop.sv */
`timescale 1ns/100ps

module decodeTop (
  input  logic            clk,
  input  logic            arstN,
  input  logic            instrValid,
  input  logic [31:0]     instr,
  input  decodePkg::wbT   wb,
  output logic            idExValid,
  output decodePkg::idExT idExOut
);

  import decodePkg::*;

  fetchT fetchData;
  logic  fetchValid;
  fetchT ifIdData;
  logic  ifIdValid;
  idExT  decoded;

  instrFetch u_fetch (
    .clk       (clk),
    .arstN     (arstN),
    .instrValid(instrValid),
    .instr     (instr),
    .fetchOut  (fetchData),
    .fetchValid(fetchValid)
  );

  // IF/ID buffer
  pipeReg #(.payloadT(fetchT)) u_ifId (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (fetchValid),
    .inData  (fetchData),
    .outValid(ifIdValid),
    .outData (ifIdData)
  );

  decodeStage u_decode (
    .clk    (clk),
    .arstN  (arstN),
    .fetchIn(ifIdData),
    .wb     (wb),
    .idOut  (decoded)
  );

  // ID/EX buffer
  pipeReg #(.payloadT(idExT)) u_idEx (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (ifIdValid),
    .inData  (decoded),
    .outValid(idExValid),
    .outData (idExOut)
  );

endmodule

/* rtl/instrFetch.sv */
`timescale 1ns/100ps

module instrFetch (
  input  logic                clk,
  input  logic                arstN,
  input  logic                instrValid,
  input  logic [31:0]         instr,
  output decodePkg::fetchT    fetchOut,
  output logic                fetchValid
);

  import decodePkg::*;

  logic [31:0] pc;

  // Bubbles leave the counter alone
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      pc <= '0;
    else if (instrValid)
      pc <= pc + pcStep;
  end

  assign fetchOut.pc    = pc;
  assign fetchOut.instr = instr;
  assign fetchValid     = instrValid;

  pcAligned: assert property (
    @(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

/* rtl/pipeReg.sv */
`timescale 1ns/100ps

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    inValid,
  input  payloadT inData,
  output logic    outValid,
  output payloadT outData
);

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      outValid <= 1'b0;
    else
      outValid <= inValid;
  end

  // Payload only moves with a valid word
  always_ff @(posedge clk)
  begin
    if (inValid)
      outData <= inData;
  end

  validKnown: assert property (
    @(posedge clk) disable iff (!arstN) !$isunknown(outValid)
  ) else $error("outValid unknown after reset");

endmodule

/* sources.f */
rtl/decodePkg.sv
rtl/instrFetch.sv
rtl/pipeReg.sv
rtl/controlUnit.sv
rtl/decodeStage.sv
rtl/decodeTop.sv
test/decodeTb.sv

/* test/decodeTb.sv */
`timescale 1ns/100ps

module decodeTb;

  import decodePkg::*;

  localparam int clkPeriod   = 100;
  localparam int resetCycles = 10;
  localparam int testCycles  = 400;
  localparam int drainCycles = 5;
  localparam int timeoutNs   = (resetCycles + testCycles + drainCycles + 20) * clkPeriod;

  logic        clk;
  logic        arstN;
  logic        instrValid;
  logic [31:0] instr;
  wbT          wb;
  logic        idExValid;
  idExT        idExOut;

  logic [15:0] lfsr = 16'd22052;
  logic [31:0] shadow [32];
  logic [31:0] pcModel;
  logic        pendValid;
  fetchT       pend;
  idExT        expQ [$];
  int          valErrors = 0;
  int          seqErrors = 0;

  decodeTop u_decodeTop (
    .clk       (clk),
    .arstN     (arstN),
    .instrValid(instrValid),
    .instr     (instr),
    .wb        (wb),
    .idExValid (idExValid),
    .idExOut   (idExOut)
  );

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrNext(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Low registers half the time so bypass and r0 get hit often
  function automatic logic [4:0] pickReg();
    if (randBits(1) != 0)
      return 5'(randBits(3));
    return 5'(randBits(5));
  endfunction

  function automatic logic [5:0] pickOpcode(input logic [3:0] sel);
    case (sel)
      4'd0:    return opR;
      4'd1:    return opAddi;
      4'd2:    return opLw;
      4'd3:    return opLh;
      4'd4:    return opLhu;
      4'd5:    return opSw;
      4'd6:    return opBeq;
      4'd7:    return opAndi;
      4'd8:    return opOri;
      default: return 6'(randBits(6));
    endcase
  endfunction

  function automatic logic [31:0] regValue(input logic [4:0] addr, input wbT w);
    if (addr == 5'd0)
      return '0;
    if (w.en && w.addr == addr)
      return w.data;
    return shadow[addr];
  endfunction

  // Expected ID/EX bundle for one instruction
  function automatic idExT expectBundle(input fetchT f, input wbT w);
    idExT       e;
    ctrlT       c;
    logic [5:0] op;
    op         = f.instr[31:26];
    c          = '0;
    c.regWrite = 1'b1;
    c.memToReg = 1'b1;
    c.aluOp    = aluAdd;
    c.loadMode = loadWord;
    case (op)
      opR:
      begin
        c.regDst = 1'b1;
        c.aluOp  = aluFunct;
      end
      opAddi:
        c.aluSrc = 1'b1;
      opLw, opLh, opLhu:
      begin
        c.aluSrc   = 1'b1;
        c.memRead  = 1'b1;
        c.memToReg = 1'b0;
        c.loadMode = (op == opLh) ? loadHalf : (op == opLhu) ? loadHalfU : loadWord;
      end
      opSw:
      begin
        c.regWrite = 1'b0;
        c.aluSrc   = 1'b1;
        c.memWrite = 1'b1;
      end
      opBeq:
      begin
        c.regWrite = 1'b0;
        c.aluOp    = aluSub;
        c.branch   = 1'b1;
      end
      opAndi:
      begin
        c.aluSrc = 1'b1;
        c.aluOp  = aluAnd;
      end
      opOri:
      begin
        c.aluSrc = 1'b1;
        c.aluOp  = aluOr;
      end
      default:
        c.regWrite = 1'b0;
    endcase
    e.pc      = f.pc;
    e.ctrl    = c;
    e.rsData  = regValue(f.instr[25:21], w);
    e.rtData  = regValue(f.instr[20:16], w);
    e.immExt  = {{16{f.instr[15]}}, f.instr[15:0]};
    e.destReg = c.regDst ? f.instr[15:11] : f.instr[20:16];
    e.funct   = f.instr[5:0];
    return e;
  endfunction

  task automatic showMismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    valErrors++;
    $display("[FAIL] %s expected %h got %h at %0t", name, exp, got, $time);
  endtask

  task automatic checkBit(input string name, input logic exp, input logic got);
    if (got !== exp)
      showMismatch(name, 32'(exp), 32'(got));
  endtask

  task automatic checkCtrl(input ctrlT exp, input ctrlT got);
    if (got !== exp)
      showMismatch("idExOut.ctrl", 32'(exp), 32'(got));
  endtask

  task automatic checkIdEx(input idExT exp, input idExT got);
    checkCtrl(exp.ctrl, got.ctrl);
    if (got.pc !== exp.pc) showMismatch("idExOut.pc", exp.pc, got.pc);
    if (got.rsData !== exp.rsData) showMismatch("idExOut.rsData", exp.rsData, got.rsData);
    if (got.rtData !== exp.rtData) showMismatch("idExOut.rtData", exp.rtData, got.rtData);
    if (got.immExt !== exp.immExt) showMismatch("idExOut.immExt", exp.immExt, got.immExt);
    if (got.destReg !== exp.destReg)
      showMismatch("idExOut.destReg", 32'(exp.destReg), 32'(got.destReg));
    if (got.funct !== exp.funct)
      showMismatch("idExOut.funct", 32'(exp.funct), 32'(got.funct));
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Shadow of fetch, IF/ID and the register file
  always @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < 32; i++)
        shadow[i] = '0;
      pcModel   = '0;
      pendValid = 1'b0;
    end
    else
    begin
      // IF/ID content moves into ID/EX on this edge
      if (pendValid)
        expQ.push_back(expectBundle(pend, wb));
      if (wb.en && wb.addr != 5'd0)
        shadow[wb.addr] = wb.data;
      pendValid = instrValid;
      if (instrValid)
      begin
        pend.pc    = pcModel;
        pend.instr = instr;
        pcModel    = pcModel + 32'd4;
      end
    end
  end

  always @(negedge clk)
  begin
    idExT exp;
    if (expQ.size() == 0)
    begin
      if (idExValid !== 1'b0)
      begin
        seqErrors++;
        $display("idExValid raised at %0t with no result expected", $time);
      end
    end
    else
    begin
      exp = expQ.pop_front();
      checkBit("idExValid", 1'b1, idExValid);
      if (idExValid === 1'b1)
        checkIdEx(exp, idExOut);
    end
  end

  initial
  begin
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] low;
    arstN      = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    wb         = '0;
    repeat (resetCycles) @(negedge clk);
    arstN = 1'b1;
    for (int cyc = 0; cyc < testCycles; cyc++)
    begin
      @(negedge clk);
      // Opening burst walks the known opcodes back to back
      if (cyc < 9)
      begin
        instrValid = 1'b1;
        op         = pickOpcode(4'(cyc));
      end
      else
      begin
        instrValid = (randBits(2) != 0);
        op         = pickOpcode(4'(randBits(4)));
      end
      rs      = pickReg();
      rt      = pickReg();
      low     = 16'(randBits(16));
      instr   = {op, rs, rt, low};
      wb.en   = 1'(randBits(1));
      wb.addr = pickReg();
      wb.data = randBits(32);
    end
    @(negedge clk);
    instrValid = 1'b0;
    wb         = '0;
    repeat (drainCycles) @(negedge clk);
    @(posedge clk);
    if (expQ.size() != 0 || pendValid)
    begin
      seqErrors++;
      $display("%0d expected results never appeared on idExOut", expQ.size());
    end
    $display("Errors: %0d value, %0d sequence", valErrors, seqErrors);
    if (valErrors + seqErrors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    #(timeoutNs);
    $display("Watchdog expired before the test finished");
    $display("** FAIL **");
    $finish;
  end

endmodule
